// File: cpu_isa_pkg.sv
// Instruction set definitions for the 16-bit load/store core
// Datapath width, register count and instruction field positions
// Opcode encodings as an enum

package cpu_isa_pkg;

  ////////////////////
  // Datapath sizes
  ////////////////////
  localparam int data_w     = 16;                 // Register and ALU width
  localparam int num_regs   = 16;                 // R0 reads as zero
  localparam int reg_addr_w = $clog2(num_regs);   // 4 bit register index
  localparam int instr_w    = 16;                 // One instruction word

  // Field positions, opcode[15:12] rd[11:8] rs[7:4] rt/imm[3:0]
  localparam int op_lsb = 12;
  localparam int rd_lsb = 8;
  localparam int rs_lsb = 4;
  localparam int rt_lsb = 0;    // Also the low end of imm8 for LLB/LHB

  ////////////////////
  // Opcodes
  ////////////////////
  typedef enum logic [3:0] {
    op_add = 4'h0,
    op_sub = 4'h1,
    op_xor = 4'h2,
    op_and = 4'h3,
    op_sll = 4'h4,
    op_sra = 4'h5,
    op_ror = 4'h6,
    op_lw  = 4'h8,   // rd <- mem[rs + simm4]
    op_sw  = 4'h9,   // mem[rs + simm4] <- rd
    op_llb = 4'ha,   // Low byte of rd from imm8
    op_lhb = 4'hb,   // High byte of rd from imm8
    op_pcs = 4'he,   // rd <- next PC
    op_hlt = 4'hf
  } opcode_t;

endpackage

// File: cpu_pipe_pkg.sv
// Pipeline payload types for the ID/EX and EX/MEM registers
// Data memory depth

package cpu_pipe_pkg;

  localparam int mem_depth = 256;   // Words of data memory

  // Decode to execute
  typedef struct packed {
    cpu_isa_pkg::opcode_t                opcode;
    logic [cpu_isa_pkg::data_w-1:0]      rs_val;
    logic [cpu_isa_pkg::data_w-1:0]      rt_val;    // rd value for SW, LLB, LHB
    logic [7:0]                          imm8;
    logic [cpu_isa_pkg::data_w-1:0]      pc_next;
    logic                                mem_enable;
    logic                                mem_write;
    logic [cpu_isa_pkg::reg_addr_w-1:0]  rd;
    logic                                reg_write;
    logic                                mem_to_reg;
    logic                                hlt;
    logic                                pcs;
  } id_ex_t;

  // Execute to result stage
  typedef struct packed {
    logic [cpu_isa_pkg::data_w-1:0]      pc_next;
    logic [cpu_isa_pkg::data_w-1:0]      alu_out;
    logic [cpu_isa_pkg::data_w-1:0]      mem_write_data;
    logic                                mem_enable;
    logic                                mem_write;
    logic [cpu_isa_pkg::reg_addr_w-1:0]  rd;
    logic                                reg_write;
    logic                                mem_to_reg;
    logic                                hlt;
    logic                                pcs;
  } ex_mem_t;

endpackage

// File: reg_file.sv
// Sixteen entry register file, R0 hardwired to zero
// Two operand read ports and a third port for store / byte-load data
// Write-before-read bypass on every read port

module reg_file (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [cpu_isa_pkg::reg_addr_w-1:0]  rd_addr_a,
  input  logic [cpu_isa_pkg::reg_addr_w-1:0]  rd_addr_b,
  input  logic [cpu_isa_pkg::reg_addr_w-1:0]  rd_addr_c,
  input  logic                                wr_en,
  input  logic [cpu_isa_pkg::reg_addr_w-1:0]  wr_addr,
  input  logic [cpu_isa_pkg::data_w-1:0]      wr_data,
  output logic [cpu_isa_pkg::data_w-1:0]      rd_data_a,
  output logic [cpu_isa_pkg::data_w-1:0]      rd_data_b,
  output logic [cpu_isa_pkg::data_w-1:0]      rd_data_c
);

  logic [cpu_isa_pkg::num_regs-1:1][cpu_isa_pkg::data_w-1:0] regs;  // No storage for R0

  // One lookup shared by the three ports
  function automatic logic [cpu_isa_pkg::data_w-1:0] read_port(
    input logic [cpu_isa_pkg::reg_addr_w-1:0] addr
  );
    if (addr == '0)
      return '0;                          // R0 always zero
    if (wr_en && wr_addr == addr)
      return wr_data;                     // New value seen in the write cycle
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '0;
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  always_comb begin
    rd_data_a = read_port(rd_addr_a);
    rd_data_b = read_port(rd_addr_b);
    rd_data_c = read_port(rd_addr_c);
  end

  // Writes aimed at R0 leave the whole file untouched
  r0_write_ignored: assert property (@(posedge clk) disable iff (rst)
    (wr_en && wr_addr == '0) |=> $stable(regs));

endmodule

// File: decoder.sv
// Decode stage
// Field split, source usage, memory / write-back control generation
// Read-after-write interlock against ID/EX and EX/MEM

module decoder (
  input  logic [cpu_isa_pkg::instr_w-1:0]     instr,
  input  logic [cpu_isa_pkg::data_w-1:0]      pc_next,
  input  logic [cpu_isa_pkg::reg_addr_w-1:0]  exec_rd,         // Destination in ID/EX
  input  logic                                exec_reg_write,
  input  logic [cpu_isa_pkg::reg_addr_w-1:0]  mem_rd,          // Destination in EX/MEM
  input  logic                                mem_reg_write,
  input  logic [cpu_isa_pkg::data_w-1:0]      rs_val,
  input  logic [cpu_isa_pkg::data_w-1:0]      rt_val,
  input  logic [cpu_isa_pkg::data_w-1:0]      rd_val,
  output logic [cpu_isa_pkg::reg_addr_w-1:0]  rs_addr,
  output logic [cpu_isa_pkg::reg_addr_w-1:0]  rt_addr,
  output logic [cpu_isa_pkg::reg_addr_w-1:0]  rd_addr,
  output cpu_isa_pkg::opcode_t                opcode,
  output logic [7:0]                          imm8,
  output logic [cpu_isa_pkg::data_w-1:0]      rs_data,         // Operand A
  output logic [cpu_isa_pkg::data_w-1:0]      rt_data,         // Operand B or store data
  output logic [cpu_isa_pkg::data_w-1:0]      pc_out,          // Next PC, PCS only
  output logic                                mem_enable,
  output logic                                mem_write,
  output logic [cpu_isa_pkg::reg_addr_w-1:0]  wb_rd,
  output logic                                reg_write,
  output logic                                mem_to_reg,
  output logic                                hlt,
  output logic                                pcs,
  output logic                                stall
);

  logic use_rs, use_rt, use_rd;   // Which register fields are sources

  // Pending write to a nonzero register further down the pipe
  function automatic logic raw_hit(input logic [cpu_isa_pkg::reg_addr_w-1:0] src);
    logic ex_hit, mem_hit;
    ex_hit  = exec_reg_write && exec_rd != '0 && exec_rd == src;
    mem_hit = mem_reg_write && mem_rd != '0 && mem_rd == src;
    return ex_hit || mem_hit;
  endfunction

  ////////////////////
  // Field split
  ////////////////////
  assign opcode  = cpu_isa_pkg::opcode_t'(instr[cpu_isa_pkg::op_lsb +: 4]);
  assign rd_addr = instr[cpu_isa_pkg::rd_lsb +: cpu_isa_pkg::reg_addr_w];
  assign rs_addr = instr[cpu_isa_pkg::rs_lsb +: cpu_isa_pkg::reg_addr_w];
  assign rt_addr = instr[cpu_isa_pkg::rt_lsb +: cpu_isa_pkg::reg_addr_w];
  assign imm8    = instr[cpu_isa_pkg::rt_lsb +: 8];     // rs:rt fields for LLB/LHB
  assign wb_rd   = rd_addr;

  ////////////////////
  // Control bundles
  ////////////////////
  always_comb begin
    use_rs     = 1'b0;
    use_rt     = 1'b0;
    use_rd     = 1'b0;
    mem_enable = 1'b0;
    mem_write  = 1'b0;
    reg_write  = 1'b0;
    mem_to_reg = 1'b0;
    hlt        = 1'b0;
    pcs        = 1'b0;
    case (opcode)
      cpu_isa_pkg::op_add, cpu_isa_pkg::op_sub,
      cpu_isa_pkg::op_xor, cpu_isa_pkg::op_and: begin
        use_rs    = 1'b1;
        use_rt    = 1'b1;
        reg_write = 1'b1;
      end
      cpu_isa_pkg::op_sll, cpu_isa_pkg::op_sra, cpu_isa_pkg::op_ror: begin
        use_rs    = 1'b1;   // Shift amount is the imm field
        reg_write = 1'b1;
      end
      cpu_isa_pkg::op_lw: begin
        use_rs     = 1'b1;
        mem_enable = 1'b1;
        reg_write  = 1'b1;
        mem_to_reg = 1'b1;
      end
      cpu_isa_pkg::op_sw: begin
        use_rs     = 1'b1;
        use_rd     = 1'b1;  // Store data
        mem_enable = 1'b1;
        mem_write  = 1'b1;
      end
      cpu_isa_pkg::op_llb, cpu_isa_pkg::op_lhb: begin
        use_rd    = 1'b1;   // Keeps the other byte
        reg_write = 1'b1;
      end
      cpu_isa_pkg::op_pcs: begin
        reg_write = 1'b1;
        pcs       = 1'b1;
      end
      cpu_isa_pkg::op_hlt: hlt = 1'b1;
      default: ;            // Unused codes act as a NOP
    endcase
  end

  // rd value rides in the rt slot whenever rd is a source
  assign rs_data = rs_val;
  assign rt_data = use_rd ? rd_val : rt_val;
  assign pc_out  = pcs ? pc_next : '0;

  // Interlock, held until the producer has written back
  assign stall = (use_rs && raw_hit(rs_addr)) ||
                 (use_rt && raw_hit(rt_addr)) ||
                 (use_rd && raw_hit(rd_addr));

  // PCS and HLT read no registers and must never wait
  always_comb begin
    no_src_no_stall: assert final (!(stall &&
      (opcode == cpu_isa_pkg::op_pcs || opcode == cpu_isa_pkg::op_hlt)));
  end

endmodule

// File: pipe_stall_reg.sv
// Generic pipeline register for any packed payload
// Reset and bubble load zero, stall holds, otherwise load

module pipe_stall_reg #(
  parameter type payload_t = logic
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      stall,    // Hold current contents
  input  logic      bubble,   // Insert an all-zero NOP
  input  payload_t  d,
  output payload_t  q
);

  always_ff @(posedge clk) begin
    if (rst || bubble) begin
      q <= '0;                // Zero payload has no enables set
    end else if (!stall) begin
      q <= d;
    end
  end

  // Callers gate one with the other
  stall_bubble_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(bubble && stall));

endmodule

// File: alu.sv
// Execute stage ALU
// Add/sub, logic ops, shifts and rotate by imm
// Byte loads into rd and load/store address generation

module alu (
  input  cpu_isa_pkg::opcode_t            opcode,
  input  logic [cpu_isa_pkg::data_w-1:0]  rs_val,
  input  logic [cpu_isa_pkg::data_w-1:0]  rt_val,   // rd value for LLB/LHB
  input  logic [7:0]                      imm8,
  output logic [cpu_isa_pkg::data_w-1:0]  alu_out
);

  logic [3:0]                        shamt;      // imm[3:0]
  logic [cpu_isa_pkg::data_w-1:0]    offset;     // Sign-extended imm[3:0]
  logic [2*cpu_isa_pkg::data_w-1:0]  rot;        // Doubled word for rotate

  assign shamt  = imm8[3:0];
  assign offset = {{(cpu_isa_pkg::data_w-4){imm8[3]}}, imm8[3:0]};
  assign rot    = {rs_val, rs_val} >> shamt;

  always_comb begin
    case (opcode)
      cpu_isa_pkg::op_add: alu_out = rs_val + rt_val;        // Wraps at 16 bits
      cpu_isa_pkg::op_sub: alu_out = rs_val - rt_val;
      cpu_isa_pkg::op_xor: alu_out = rs_val ^ rt_val;
      cpu_isa_pkg::op_and: alu_out = rs_val & rt_val;
      cpu_isa_pkg::op_sll: alu_out = rs_val << shamt;
      cpu_isa_pkg::op_sra: alu_out = $signed(rs_val) >>> shamt;
      cpu_isa_pkg::op_ror: alu_out = rot[cpu_isa_pkg::data_w-1:0];
      // Byte loads keep the other half of rd
      cpu_isa_pkg::op_llb: alu_out = {rt_val[15:8], imm8};
      cpu_isa_pkg::op_lhb: alu_out = {imm8, rt_val[7:0]};
      // Word address for memory ops
      cpu_isa_pkg::op_lw,
      cpu_isa_pkg::op_sw:  alu_out = rs_val + offset;
      default:             alu_out = '0;   // PCS, HLT and unused codes
    endcase
  end

endmodule

// File: mem_wb_stage.sv
// Result stage
// Data memory with synchronous write and combinational read
// Write-back select and sticky halt

module mem_wb_stage (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                freeze,
  input  logic [cpu_isa_pkg::data_w-1:0]      alu_out,          // Result or memory address
  input  logic [cpu_isa_pkg::data_w-1:0]      pc_next,
  input  logic [cpu_isa_pkg::data_w-1:0]      mem_write_data,
  input  logic                                mem_enable,
  input  logic                                mem_write,
  input  logic [cpu_isa_pkg::reg_addr_w-1:0]  rd,
  input  logic                                reg_write,
  input  logic                                mem_to_reg,
  input  logic                                hlt,
  input  logic                                pcs,
  output logic                                wb_en,
  output logic [cpu_isa_pkg::reg_addr_w-1:0]  wb_rd,
  output logic [cpu_isa_pkg::data_w-1:0]      wb_data,
  output logic                                halted
);

  localparam int addr_w = $clog2(cpu_pipe_pkg::mem_depth);

  logic [cpu_isa_pkg::data_w-1:0] mem [cpu_pipe_pkg::mem_depth];
  logic [addr_w-1:0]              addr;
  logic [cpu_isa_pkg::data_w-1:0] rd_word;
  logic                           live;       // Stage may commit this cycle

  assign addr    = alu_out[addr_w-1:0];
  assign rd_word = mem[addr];
  assign live    = !halted && !freeze;

  ////////////////////
  // Data memory
  ////////////////////
  always_ff @(posedge clk) begin
    if (mem_enable && mem_write && live) begin
      mem[addr] <= mem_write_data;
    end
  end

  // Sticky until reset, frozen cycles do not count
  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
    end else if (hlt && !freeze) begin
      halted <= 1'b1;
    end
  end

  ////////////////////
  // Write-back
  ////////////////////
  assign wb_en   = reg_write && live;
  assign wb_rd   = rd;
  assign wb_data = mem_to_reg ? rd_word :
                   pcs        ? pc_next : alu_out;

  // Once halted, no further write-back and halt stays set
  halt_is_final: assert property (@(posedge clk) disable iff (rst)
    halted |-> !wb_en ##1 halted);

endmodule

// File: cpu_core.sv
// Pipeline core top level
// Decode, ID/EX, execute, EX/MEM, result stage and register file

module cpu_core (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [cpu_isa_pkg::instr_w-1:0]     instr,
  input  logic [cpu_isa_pkg::data_w-1:0]      pc_next,
  input  logic                                freeze,
  output logic                                stall,     // Hold instr at the source
  output logic                                wb_en,
  output logic [cpu_isa_pkg::reg_addr_w-1:0]  wb_rd,
  output logic [cpu_isa_pkg::data_w-1:0]      wb_data,
  output logic                                halted
);

  logic [cpu_isa_pkg::reg_addr_w-1:0] rs_addr, rt_addr, rd_addr;
  logic [cpu_isa_pkg::data_w-1:0]     rs_val, rt_val, rd_val;
  logic [cpu_isa_pkg::data_w-1:0]     alu_out;
  cpu_pipe_pkg::id_ex_t               id_ex_d, id_ex_q;
  cpu_pipe_pkg::ex_mem_t              ex_mem_d, ex_mem_q;

  reg_file u_rf (
    .clk(clk), .rst(rst),
    .rd_addr_a(rs_addr), .rd_addr_b(rt_addr), .rd_addr_c(rd_addr),
    .wr_en(wb_en), .wr_addr(wb_rd), .wr_data(wb_data),
    .rd_data_a(rs_val), .rd_data_b(rt_val), .rd_data_c(rd_val)
  );

  // Decoder outputs land straight in the ID/EX payload
  decoder u_dec (
    .instr(instr), .pc_next(pc_next),
    .exec_rd(id_ex_q.rd), .exec_reg_write(id_ex_q.reg_write),
    .mem_rd(ex_mem_q.rd), .mem_reg_write(ex_mem_q.reg_write),
    .rs_val(rs_val), .rt_val(rt_val), .rd_val(rd_val),
    .rs_addr(rs_addr), .rt_addr(rt_addr), .rd_addr(rd_addr),
    .opcode(id_ex_d.opcode), .imm8(id_ex_d.imm8),
    .rs_data(id_ex_d.rs_val), .rt_data(id_ex_d.rt_val), .pc_out(id_ex_d.pc_next),
    .mem_enable(id_ex_d.mem_enable), .mem_write(id_ex_d.mem_write),
    .wb_rd(id_ex_d.rd), .reg_write(id_ex_d.reg_write), .mem_to_reg(id_ex_d.mem_to_reg),
    .hlt(id_ex_d.hlt), .pcs(id_ex_d.pcs), .stall(stall)
  );

  ////////////////////
  // ID/EX
  ////////////////////
  pipe_stall_reg #(.payload_t(cpu_pipe_pkg::id_ex_t)) u_id_ex (
    .clk(clk), .rst(rst),
    .stall(freeze),
    .bubble(stall && !freeze),    // Hazard inserts a NOP unless frozen
    .d(id_ex_d), .q(id_ex_q)
  );

  alu u_alu (
    .opcode(id_ex_q.opcode), .rs_val(id_ex_q.rs_val), .rt_val(id_ex_q.rt_val),
    .imm8(id_ex_q.imm8), .alu_out(alu_out)
  );

  // Store data comes from the rt slot
  assign ex_mem_d = '{
    pc_next:        id_ex_q.pc_next,
    alu_out:        alu_out,
    mem_write_data: id_ex_q.rt_val,
    mem_enable:     id_ex_q.mem_enable,
    mem_write:      id_ex_q.mem_write,
    rd:             id_ex_q.rd,
    reg_write:      id_ex_q.reg_write,
    mem_to_reg:     id_ex_q.mem_to_reg,
    hlt:            id_ex_q.hlt,
    pcs:            id_ex_q.pcs
  };

  ////////////////////
  // EX/MEM
  ////////////////////
  pipe_stall_reg #(.payload_t(cpu_pipe_pkg::ex_mem_t)) u_ex_mem (
    .clk(clk), .rst(rst),
    .stall(freeze),
    .bubble(halted && !freeze),   // Drain after halt
    .d(ex_mem_d), .q(ex_mem_q)
  );

  mem_wb_stage u_mem_wb (
    .clk(clk), .rst(rst), .freeze(freeze),
    .alu_out(ex_mem_q.alu_out), .pc_next(ex_mem_q.pc_next),
    .mem_write_data(ex_mem_q.mem_write_data),
    .mem_enable(ex_mem_q.mem_enable), .mem_write(ex_mem_q.mem_write),
    .rd(ex_mem_q.rd), .reg_write(ex_mem_q.reg_write), .mem_to_reg(ex_mem_q.mem_to_reg),
    .hlt(ex_mem_q.hlt), .pcs(ex_mem_q.pcs),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .halted(halted)
  );

endmodule

// File: tb_cpu_core.sv
// Testbench for the pipelined 16-bit core
// Program table applied in a loop, sequential reference model
// Clock, reset, timeout, write-back / interlock / freeze / halt checks

module tb_cpu_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [15:0] idle_instr = 16'h7000;   // Unused opcode, decodes as a NOP

  logic        clk, rst, freeze, stall, wb_en, halted;
  logic [15:0] instr, pc_next, wb_data;
  logic [3:0]  wb_rd;

  // Program table, one entry per row
  string       row_name[$];
  logic [15:0] row_instr[$];
  logic [15:0] row_pc[$];
  bit          row_freeze[$];     // Hold the core one cycle before issue
  bit          row_hazard[$];     // Interlock stall expected on this row

  // Reference model state
  logic [15:0] ref_regs[16];
  logic [15:0] ref_mem[256];
  logic [3:0]  exp_rd_q[$];
  logic [15:0] exp_data_q[$];
  string       exp_name_q[$];
  bit          halt_issued, halt_seen, first_wb_done;

  integer seed;
  int     cycles, cycle_limit, first_issue_cycle, errors, row;
  bit     stall_seen, froze;

  cpu_core u_dut (
    .clk(clk), .rst(rst), .instr(instr), .pc_next(pc_next), .freeze(freeze),
    .stall(stall), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  ////////////////////
  // Failure reporting
  ////////////////////
  task automatic stop_on_failure();
    errors++;
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at first failure");
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    stop_on_failure();
  endtask

  task automatic report_mismatch(input string name, input string what,
                                 input logic [15:0] exp, input logic [15:0] act);
    $display("ERROR %s: %s expected 0x%04h actual 0x%04h", name, what, exp, act);
    stop_on_failure();
  endtask

  ////////////////////
  // Program table
  ////////////////////
  function automatic logic [15:0] encode(input logic [3:0] op, input logic [3:0] rd,
                                         input logic [3:0] rs, input logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] encode_imm(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [7:0] imm);
    return {op, rd, imm};   // LLB / LHB byte in the rs:rt fields
  endfunction

  task automatic add_row(input string name, input logic [15:0] ins, input bit frz,
                         input bit haz);
    row_name.push_back(name);
    row_instr.push_back(ins);
    row_pc.push_back(16'h0100 + 16'(2 * row_instr.size()));  // Next PC of this slot
    row_freeze.push_back(frz);
    row_hazard.push_back(haz);
  endtask

  task automatic build_table();
    logic [3:0] off[4];
    // Constants from byte loads, spaced so nothing interlocks
    add_row("llb_r1",  encode_imm(cpu_isa_pkg::op_llb, 4'd1, 8'h34), 1'b0, 1'b0);
    add_row("llb_r2",  encode_imm(cpu_isa_pkg::op_llb, 4'd2, 8'hf0), 1'b0, 1'b0);
    add_row("llb_r3",  encode_imm(cpu_isa_pkg::op_llb, 4'd3, 8'h0f), 1'b0, 1'b0);
    add_row("lhb_r1",  encode_imm(cpu_isa_pkg::op_lhb, 4'd1, 8'h12), 1'b0, 1'b0);
    add_row("lhb_r2",  encode_imm(cpu_isa_pkg::op_lhb, 4'd2, 8'h8a), 1'b0, 1'b0);
    add_row("lhb_r3",  encode_imm(cpu_isa_pkg::op_lhb, 4'd3, 8'h00), 1'b0, 1'b0);
    add_row("llb_r7",  encode_imm(cpu_isa_pkg::op_llb, 4'd7, 8'h5a), 1'b0, 1'b0);
    add_row("llb_r8",  encode_imm(cpu_isa_pkg::op_llb, 4'd8, 8'hc3), 1'b0, 1'b0);
    // ALU ops on settled sources
    add_row("add",     encode(cpu_isa_pkg::op_add, 4'd4, 4'd1, 4'd2), 1'b0, 1'b0);
    add_row("sub",     encode(cpu_isa_pkg::op_sub, 4'd5, 4'd1, 4'd3), 1'b0, 1'b0);
    add_row("xor",     encode(cpu_isa_pkg::op_xor, 4'd6, 4'd2, 4'd3), 1'b0, 1'b0);
    add_row("and",     encode(cpu_isa_pkg::op_and, 4'd9, 4'd1, 4'd2), 1'b0, 1'b0);
    add_row("sll",     encode(cpu_isa_pkg::op_sll, 4'd10, 4'd1, 4'd4), 1'b0, 1'b0);
    add_row("sra",     encode(cpu_isa_pkg::op_sra, 4'd11, 4'd2, 4'd3), 1'b0, 1'b0);
    add_row("ror8",    encode(cpu_isa_pkg::op_ror, 4'd12, 4'd1, 4'd8), 1'b0, 1'b0);
    add_row("ror0",    encode(cpu_isa_pkg::op_ror, 4'd13, 4'd2, 4'd0), 1'b0, 1'b0);
    // Back-to-back dependent chain
    add_row("raw_sub", encode(cpu_isa_pkg::op_sub, 4'd5, 4'd2, 4'd1), 1'b0, 1'b0);
    add_row("raw_add", encode(cpu_isa_pkg::op_add, 4'd6, 4'd5, 4'd3), 1'b0, 1'b1);
    add_row("raw_xor", encode(cpu_isa_pkg::op_xor, 4'd9, 4'd6, 4'd5), 1'b0, 1'b1);
    add_row("raw_sll", encode(cpu_isa_pkg::op_sll, 4'd10, 4'd9, 4'd1), 1'b0, 1'b1);
    // Stores then loads at random offsets from R7
    for (int i = 0; i < 4; i++) off[i] = 4'($random(seed));
    add_row("sw_0",    encode(cpu_isa_pkg::op_sw, 4'd1, 4'd7, off[0]), 1'b0, 1'b0);
    add_row("sw_1",    encode(cpu_isa_pkg::op_sw, 4'd2, 4'd7, off[1]), 1'b0, 1'b0);
    add_row("sw_2",    encode(cpu_isa_pkg::op_sw, 4'd4, 4'd7, off[2]), 1'b0, 1'b0);
    add_row("llb_r14", encode_imm(cpu_isa_pkg::op_llb, 4'd14, 8'h99), 1'b0, 1'b0);
    add_row("sw_3",    encode(cpu_isa_pkg::op_sw, 4'd14, 4'd7, off[3]), 1'b0, 1'b1);
    add_row("lw_0",    encode(cpu_isa_pkg::op_lw, 4'd15, 4'd7, off[0]), 1'b0, 1'b0);
    add_row("lw_1",    encode(cpu_isa_pkg::op_lw, 4'd11, 4'd7, off[1]), 1'b0, 1'b0);
    add_row("lw_2",    encode(cpu_isa_pkg::op_lw, 4'd12, 4'd7, off[2]), 1'b0, 1'b0);
    add_row("lw_3",    encode(cpu_isa_pkg::op_lw, 4'd13, 4'd7, off[3]), 1'b0, 1'b0);
    add_row("pcs_r10", encode(cpu_isa_pkg::op_pcs, 4'd10, 4'd0, 4'd0), 1'b0, 1'b0);
    add_row("add_ld",  encode(cpu_isa_pkg::op_add, 4'd8, 4'd15, 4'd11), 1'b0, 1'b0);
    // Freeze while results are in flight
    add_row("frz_llb", encode_imm(cpu_isa_pkg::op_llb, 4'd1, 8'h55), 1'b1, 1'b0);
    add_row("frz_add", encode(cpu_isa_pkg::op_add, 4'd2, 4'd1, 4'd3), 1'b1, 1'b0);
    add_row("frz_xor", encode(cpu_isa_pkg::op_xor, 4'd3, 4'd2, 4'd2), 1'b0, 1'b0);
    add_row("frz_pcs", encode(cpu_isa_pkg::op_pcs, 4'd4, 4'd0, 4'd0), 1'b1, 1'b0);
    add_row("frz_sub", encode(cpu_isa_pkg::op_sub, 4'd5, 4'd4, 4'd10), 1'b1, 1'b0);
    // Halt, rows behind it must not write back
    add_row("hlt",     encode(cpu_isa_pkg::op_hlt, 4'd0, 4'd0, 4'd0), 1'b0, 1'b0);
    add_row("post_llb", encode_imm(cpu_isa_pkg::op_llb, 4'd6, 8'hee), 1'b0, 1'b0);
    add_row("post_add", encode(cpu_isa_pkg::op_add, 4'd9, 4'd1, 4'd2), 1'b0, 1'b0);
    add_row("post_pcs", encode(cpu_isa_pkg::op_pcs, 4'd11, 4'd0, 4'd0), 1'b0, 1'b0);
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  // Executes one issued instruction in program order
  task automatic model_exec(input string name, input logic [15:0] ins, input logic [15:0] pc);
    logic [3:0]  op, rd, rs, rt;
    logic [15:0] a, b, d, res, addr;
    bit          wr;
    op   = ins[15:12];
    rd   = ins[11:8];
    rs   = ins[7:4];
    rt   = ins[3:0];
    a    = ref_regs[rs];
    b    = ref_regs[rt];
    d    = ref_regs[rd];            // Store data or byte-load base
    addr = a + {{12{rt[3]}}, rt};   // Base plus signed 4-bit offset
    wr   = 1'b1;
    res  = '0;
    if (halt_issued) return;        // Nothing after HLT commits
    case (op)
      cpu_isa_pkg::op_add: res = a + b;
      cpu_isa_pkg::op_sub: res = a - b;
      cpu_isa_pkg::op_xor: res = a ^ b;
      cpu_isa_pkg::op_and: res = a & b;
      cpu_isa_pkg::op_sll: res = a << rt;
      cpu_isa_pkg::op_sra: res = $signed(a) >>> rt;
      cpu_isa_pkg::op_ror: res = (a >> rt) | (a << (16 - rt));
      cpu_isa_pkg::op_lw:  res = ref_mem[addr[7:0]];
      cpu_isa_pkg::op_sw: begin
        ref_mem[addr[7:0]] = d;
        wr = 1'b0;
      end
      cpu_isa_pkg::op_llb: res = {d[15:8], ins[7:0]};
      cpu_isa_pkg::op_lhb: res = {ins[7:0], d[7:0]};
      cpu_isa_pkg::op_pcs: res = pc;
      cpu_isa_pkg::op_hlt: begin
        halt_issued = 1'b1;
        wr = 1'b0;
      end
      default: wr = 1'b0;
    endcase
    if (wr) begin
      if (rd != 4'd0) ref_regs[rd] = res;
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(res);
      exp_name_q.push_back(name);
    end
  endtask

  ////////////////////
  // Per-cycle checks
  ////////////////////
  task automatic check_outputs();
    logic [3:0]  e_rd;
    logic [15:0] e_data;
    string       e_name;
    cycles++;
    if (cycles > cycle_limit)
      fail_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
    if (halt_seen)
      assert (halted === 1'b1) else fail_run("halted fell after it was set");
    if (halted) begin
      assert (halt_issued) else fail_run("halted rose before any HLT was issued");
      assert (wb_en === 1'b0) else fail_run("Write-back seen while halted");
      halt_seen = 1'b1;
    end
    if (freeze)
      assert (wb_en === 1'b0) else fail_run("Write-back seen while frozen");
    if (wb_en) begin
      assert (exp_rd_q.size() > 0) else fail_run("Write-back with no result pending");
      e_rd   = exp_rd_q.pop_front();
      e_data = exp_data_q.pop_front();
      e_name = exp_name_q.pop_front();
      assert (wb_rd === e_rd) else report_mismatch(e_name, "wb_rd", 16'(e_rd), 16'(wb_rd));
      assert (wb_data === e_data) else report_mismatch(e_name, "wb_data", e_data, wb_data);
      if (!first_wb_done) begin       // Two edges from issue to write-back
        assert (cycles == first_issue_cycle + 2)
          else report_mismatch(e_name, "write-back cycle", 16'(first_issue_cycle + 2),
                               16'(cycles));
        first_wb_done = 1'b1;
      end
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    seed    = 32'h1e8a8b51;
    rst     = 1'b1;
    instr   = idle_instr;
    pc_next = '0;
    freeze  = 1'b0;
    errors  = 0;
    cycles  = 0;
    for (int i = 0; i < 16; i++) ref_regs[i] = '0;
    build_table();
    cycle_limit = 4 * row_instr.size() + 40;

    // Outputs stay low through reset
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      assert (wb_en === 1'b0 && stall === 1'b0 && halted === 1'b0)
        else fail_run("Outputs not low during reset");
    end
    rst = 1'b0;
    #1;
    assert (wb_en === 1'b0 && stall === 1'b0 && halted === 1'b0)
      else fail_run("Outputs not low right after reset");

    row = 0;
    while (row < row_instr.size()) begin
      @(negedge clk);
      instr   = row_instr[row];
      pc_next = row_pc[row];
      freeze  = row_freeze[row] && !froze;
      #1;                                  // Let stall settle before sampling
      check_outputs();
      if (stall) stall_seen = 1'b1;
      if (freeze) begin
        froze = 1'b1;
      end else if (!stall) begin           // Issued at the coming edge
        assert (stall_seen || !row_hazard[row])
          else fail_run($sformatf("No interlock stall on dependent row %s", row_name[row]));
        if (row == 0) first_issue_cycle = cycles;
        model_exec(row_name[row], row_instr[row], row_pc[row]);
        row++;
        froze      = 1'b0;
        stall_seen = 1'b0;
      end
    end

    // Drain until halt and every expected result is seen
    while (!(halt_seen && exp_rd_q.size() == 0)) begin
      @(negedge clk);
      instr  = idle_instr;
      freeze = 1'b0;
      #1;
      check_outputs();
    end
    repeat (4) begin                       // halted holds, nothing more written
      @(negedge clk);
      #1;
      check_outputs();
    end

    if (errors == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "Checks failed");
    end
  end

endmodule

// File: src.f
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
reg_file.sv
decoder.sv
pipe_stall_reg.sv
alu.sv
mem_wb_stage.sv
cpu_core.sv
tb_cpu_core.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - cpu_isa_pkg.sv
  - cpu_pipe_pkg.sv
  - reg_file.sv
  - decoder.sv
  - pipe_stall_reg.sv
  - alu.sv
  - mem_wb_stage.sv
  - cpu_core.sv
  - target: test
    files:
      - tb_cpu_core.sv
